// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := ex_stage_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/ex_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'TEST PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_ctrl.sv
rtl/ex_alu.sv
rtl/ex_mul.sv
rtl/ex_branch.sv
rtl/ex_stage_reg.sv
rtl/ex_stage.sv
tb/ex_stage_properties.sv
tb/ex_stage_tb.sv

// ==== rtl/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_alu (
    input  logic [`EX_XLEN-1:0] op1,
    input  logic [`EX_XLEN-1:0] op2,
    input  ex_pkg::exe_fun_e    fun,
    output logic [`EX_XLEN-1:0] result
);

    localparam int XLEN    = `EX_XLEN;
    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sum;
    logic               lt_s;
    logic               lt_u;

    assign shamt = op2[SHAMT_W-1:0];
    assign sum   = op1 + op2;
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;

    always_comb begin
        case (fun)
            ex_pkg::alu_add: begin
                result = sum;
            end
            ex_pkg::alu_sub: begin
                result = op1 - op2;
            end
            ex_pkg::alu_and: begin
                result = op1 & op2;
            end
            ex_pkg::alu_or: begin
                result = op1 | op2;
            end
            ex_pkg::alu_xor: begin
                result = op1 ^ op2;
            end
            ex_pkg::alu_sll: begin
                result = op1 << shamt;
            end
            ex_pkg::alu_srl: begin
                result = op1 >> shamt;
            end
            ex_pkg::alu_sra: begin
                result = $signed(op1) >>> shamt;
            end
            ex_pkg::alu_slt: begin
                result = {{(XLEN-1){1'b0}}, lt_s};
            end
            ex_pkg::alu_sltu: begin
                result = {{(XLEN-1){1'b0}}, lt_u};
            end
            // jalr target is always halfword aligned
            ex_pkg::alu_jalr: begin
                result = sum & {{(XLEN-1){1'b1}}, 1'b0};
            end
            ex_pkg::alu_copy1: begin
                result = op1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== rtl/ex_branch.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_branch (
    input  logic [`EX_XLEN-1:0] op1,
    input  logic [`EX_XLEN-1:0] op2,
    input  logic [`EX_XLEN-1:0] pc,
    input  logic [`EX_XLEN-1:0] imm_b,
    input  ex_pkg::exe_fun_e    fun,
    output ex_pkg::br_res_t     res
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = op1 == op2;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        case (fun)
            ex_pkg::br_beq:  res.br_flg = eq;
            ex_pkg::br_bne:  res.br_flg = ~eq;
            ex_pkg::br_blt:  res.br_flg = lt_s;
            ex_pkg::br_bge:  res.br_flg = ~lt_s;
            ex_pkg::br_bltu: res.br_flg = lt_u;
            ex_pkg::br_bgeu: res.br_flg = ~lt_u;
            default:         res.br_flg = 1'b0;
        endcase
    end

    // target computed for every op, only br_flg qualifies it
    assign res.br_target = pc + imm_b;

endmodule

// ==== rtl/ex_ctrl.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                flush,
    input  ex_pkg::exe_fun_e    cur_fun,
    output logic                hold_sel,
    output logic                hold_clear,
    output logic                out_clear,
    output ex_pkg::unit_sel_e   unit_sel
);

    localparam bit HAS_MUL = (`EX_EXCLUDE_RV32M == 0);

    // previous cycle re-executed the held instruction
    logic stall_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall & ~flush;
        end
    end

    // flush wins: both registers drop to a bubble whatever stall says
    assign hold_sel   = stall;
    assign hold_clear = flush;
    assign out_clear  = flush;

    always_comb begin
        case (cur_fun)
            ex_pkg::alu_add, ex_pkg::alu_sub, ex_pkg::alu_and, ex_pkg::alu_or,
            ex_pkg::alu_xor, ex_pkg::alu_sll, ex_pkg::alu_srl, ex_pkg::alu_sra,
            ex_pkg::alu_slt, ex_pkg::alu_sltu, ex_pkg::alu_jalr,
            ex_pkg::alu_copy1: begin
                unit_sel = ex_pkg::unit_alu;
            end
            ex_pkg::alu_mul, ex_pkg::alu_mulh, ex_pkg::alu_mulhsu,
            ex_pkg::alu_mulhu: begin
                unit_sel = HAS_MUL ? ex_pkg::unit_mul : ex_pkg::unit_none;
            end
            // branches and alu_x leave alu_out at zero
            default: begin
                unit_sel = ex_pkg::unit_none;
            end
        endcase
    end

endmodule

// ==== rtl/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath width
`define EX_XLEN 32

// fill pattern for data fields of a bubble
`define EX_POISON {`EX_XLEN{1'b1}}

// pc carried by a bubble
`define EX_PC_NOP {`EX_XLEN{1'b0}}

// set to 1 to build the stage without the RV32M multiplier.
// multiply codes then produce zero
`define EX_EXCLUDE_RV32M 0

`endif

// ==== rtl/ex_mul.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_mul (
    input  logic [`EX_XLEN-1:0] op1,
    input  logic [`EX_XLEN-1:0] op2,
    input  ex_pkg::exe_fun_e    fun,
    output logic [`EX_XLEN-1:0] result
);

    localparam int XLEN = `EX_XLEN;

    logic signed [2*XLEN-1:0] prod_ss;
    logic signed [2*XLEN-1:0] prod_su;
    logic        [2*XLEN-1:0] prod_uu;

    assign prod_ss = $signed(op1) * $signed(op2);
    // widen by one bit so op2 stays non-negative in a signed product
    assign prod_su = $signed({op1[XLEN-1], op1}) * $signed({1'b0, op2});
    assign prod_uu = op1 * op2;

    always_comb begin
        case (fun)
            ex_pkg::alu_mul:    result = prod_ss[XLEN-1:0];
            ex_pkg::alu_mulh:   result = prod_ss[2*XLEN-1:XLEN];
            ex_pkg::alu_mulhsu: result = prod_su[2*XLEN-1:XLEN];
            ex_pkg::alu_mulhu:  result = prod_uu[2*XLEN-1:XLEN];
            default:            result = '0;
        endcase
    end

endmodule

// ==== rtl/ex_pkg.sv ====
`include "ex_defs.svh"

package ex_pkg;

    // RV32IM execute operation codes
    typedef enum logic [4:0] {
        alu_x      = 5'd0,
        alu_add    = 5'd1,
        alu_sub    = 5'd2,
        alu_and    = 5'd3,
        alu_or     = 5'd4,
        alu_xor    = 5'd5,
        alu_sll    = 5'd6,
        alu_srl    = 5'd7,
        alu_sra    = 5'd8,
        alu_slt    = 5'd9,
        alu_sltu   = 5'd10,
        br_beq     = 5'd11,
        br_bne     = 5'd12,
        br_blt     = 5'd13,
        br_bge     = 5'd14,
        br_bltu    = 5'd15,
        br_bgeu    = 5'd16,
        alu_jalr   = 5'd17,
        alu_copy1  = 5'd18,
        alu_mul    = 5'd19,
        alu_mulh   = 5'd20,
        alu_mulhsu = 5'd21,
        alu_mulhu  = 5'd22
    } exe_fun_e;

    // source of alu_out
    typedef enum logic [1:0] {
        unit_none = 2'd0,
        unit_alu  = 2'd1,
        unit_mul  = 2'd2
    } unit_sel_e;

    typedef struct packed {
        logic                valid;
        logic [`EX_XLEN-1:0] pc;
        exe_fun_e            exe_fun;
        logic [`EX_XLEN-1:0] op1;
        logic [`EX_XLEN-1:0] op2;
        logic [`EX_XLEN-1:0] rs2_data;
        logic [3:0]          mem_wen;
        logic                rf_wen;
        logic [3:0]          wb_sel;
        logic [4:0]          wb_addr;
        logic [2:0]          csr_cmd;
        logic                jmp_flg;
        logic [`EX_XLEN-1:0] imm_i;
        logic [`EX_XLEN-1:0] imm_b;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_XLEN-1:0] alu_out;
        logic [`EX_XLEN-1:0] op1;
        logic [`EX_XLEN-1:0] rs2_data;
        logic [3:0]          mem_wen;
        logic                rf_wen;
        logic [3:0]          wb_sel;
        logic [4:0]          wb_addr;
        logic [2:0]          csr_cmd;
        logic                jmp_flg;
        logic [`EX_XLEN-1:0] imm_i;
    } ex_mem_t;

    typedef struct packed {
        logic                br_flg;
        logic [`EX_XLEN-1:0] br_target;
    } br_res_t;

    // bubbles: invalid, all enables low, data poisoned
    localparam id_ex_t ID_EX_BUBBLE = '{
        valid: 1'b0, pc: `EX_PC_NOP, exe_fun: alu_x,
        op1: `EX_POISON, op2: `EX_POISON, rs2_data: `EX_POISON,
        mem_wen: 4'd0, rf_wen: 1'b0, wb_sel: 4'd0, wb_addr: 5'd0,
        csr_cmd: 3'd0, jmp_flg: 1'b0, imm_i: `EX_POISON, imm_b: `EX_POISON
    };

    localparam ex_mem_t EX_MEM_BUBBLE = '{
        valid: 1'b0, pc: `EX_PC_NOP, alu_out: `EX_POISON,
        op1: `EX_POISON, rs2_data: `EX_POISON,
        mem_wen: 4'd0, rf_wen: 1'b0, wb_sel: 4'd0, wb_addr: 5'd0,
        csr_cmd: 3'd0, jmp_flg: 1'b0, imm_i: `EX_POISON
    };

    localparam br_res_t BR_RES_BUBBLE = '{
        br_flg: 1'b0, br_target: `EX_POISON
    };

endpackage

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_pkg::id_ex_t  id_ex,
    input  logic            stall,
    input  logic            flush,
    output ex_pkg::ex_mem_t ex_mem,
    output ex_pkg::br_res_t br_res
);

    localparam bit HAS_MUL = (`EX_EXCLUDE_RV32M == 0);

    logic                hold_sel;
    logic                hold_clear;
    logic                out_clear;
    ex_pkg::unit_sel_e   unit_sel;
    ex_pkg::id_ex_t      held;
    ex_pkg::id_ex_t      cur;
    logic [`EX_XLEN-1:0] alu_result;
    logic [`EX_XLEN-1:0] mul_result;
    logic [`EX_XLEN-1:0] alu_out;
    ex_pkg::br_res_t     br_calc;
    ex_pkg::br_res_t     br_d;
    ex_pkg::ex_mem_t     ex_mem_d;

    ex_ctrl ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .cur_fun    (cur.exe_fun),
        .hold_sel   (hold_sel),
        .hold_clear (hold_clear),
        .out_clear  (out_clear),
        .unit_sel   (unit_sel)
    );

    // under stall the held copy is re-executed, id_ex is ignored
    assign cur = hold_sel ? held : id_ex;

    ex_stage_reg #(.payload_t(ex_pkg::id_ex_t)) hold_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (hold_clear),
        .d      (cur),
        .bubble (ex_pkg::ID_EX_BUBBLE),
        .q      (held)
    );

    ex_alu alu_inst (
        .op1    (cur.op1),
        .op2    (cur.op2),
        .fun    (cur.exe_fun),
        .result (alu_result)
    );

    generate
        if (HAS_MUL) begin : g_mul
            ex_mul mul_inst (
                .op1    (cur.op1),
                .op2    (cur.op2),
                .fun    (cur.exe_fun),
                .result (mul_result)
            );
        end else begin : g_no_mul
            assign mul_result = '0;
        end
    endgenerate

    ex_branch branch_inst (
        .op1   (cur.op1),
        .op2   (cur.op2),
        .pc    (cur.pc),
        .imm_b (cur.imm_b),
        .fun   (cur.exe_fun),
        .res   (br_calc)
    );

    always_comb begin
        case (unit_sel)
            ex_pkg::unit_alu: alu_out = alu_result;
            ex_pkg::unit_mul: alu_out = mul_result;
            default:          alu_out = '0;
        endcase
    end

    // an invalid slot leaves as an exact bubble
    always_comb begin
        ex_mem_d = ex_pkg::EX_MEM_BUBBLE;
        br_d     = ex_pkg::BR_RES_BUBBLE;
        if (cur.valid) begin
            ex_mem_d.valid    = 1'b1;
            ex_mem_d.pc       = cur.pc;
            ex_mem_d.alu_out  = alu_out;
            ex_mem_d.op1      = cur.op1;
            ex_mem_d.rs2_data = cur.rs2_data;
            ex_mem_d.mem_wen  = cur.mem_wen;
            ex_mem_d.rf_wen   = cur.rf_wen;
            ex_mem_d.wb_sel   = cur.wb_sel;
            ex_mem_d.wb_addr  = cur.wb_addr;
            ex_mem_d.csr_cmd  = cur.csr_cmd;
            ex_mem_d.jmp_flg  = cur.jmp_flg;
            ex_mem_d.imm_i    = cur.imm_i;
            br_d              = br_calc;
        end
    end

    ex_stage_reg #(.payload_t(ex_pkg::ex_mem_t)) out_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (out_clear),
        .d      (ex_mem_d),
        .bubble (ex_pkg::EX_MEM_BUBBLE),
        .q      (ex_mem)
    );

    ex_stage_reg #(.payload_t(ex_pkg::br_res_t)) br_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (out_clear),
        .d      (br_d),
        .bubble (ex_pkg::BR_RES_BUBBLE),
        .q      (br_res)
    );

endmodule

// ==== rtl/ex_stage_reg.sv ====
`timescale 1ns/1ps

module ex_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  payload_t d,
    input  payload_t bubble,
    output payload_t q
);

    // reset and clear both park the register on the bubble value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= bubble;
        end else if (clear) begin
            q <= bubble;
        end else begin
            q <= d;
        end
    end

endmodule

// ==== tb/ex_stage_properties.sv ====
`timescale 1ns/1ps

module ex_stage_properties (
    input logic            clk,
    input logic            rst_n,
    input logic            stall_q,
    input logic            flush,
    input ex_pkg::ex_mem_t ex_mem,
    input ex_pkg::br_res_t br_res
);

    int unsigned fail_count;

    initial fail_count = 0;

    // flush always leaves a bubble behind
    flush_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !ex_mem.valid)
        else begin
            fail_count++;
            $error("valid set on the edge after a flush");
        end

    enables_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_mem.rf_wen || ex_mem.mem_wen != 4'd0) |-> ex_mem.valid)
        else begin
            fail_count++;
            $error("write enable set in an invalid slot");
        end

    branch_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        br_res.br_flg |-> ex_mem.valid)
        else begin
            fail_count++;
            $error("br_flg set in an invalid slot");
        end

    // held instruction re-executes to the same result
    stall_holds_output: assert property (@(posedge clk) disable iff (!rst_n)
        stall_q |-> ($stable(ex_mem) && $stable(br_res)))
        else begin
            fail_count++;
            $error("outputs changed across a stalled edge");
        end

endmodule

// ==== tb/ex_stage_tb.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage_tb;

    localparam int NUM_CYCLES  = 5000;
    localparam int RESET_LIMIT = 100;

    logic            clk;
    logic            rst_n;
    ex_pkg::id_ex_t  id_ex;
    logic            stall;
    logic            flush;
    ex_pkg::ex_mem_t ex_mem;
    ex_pkg::br_res_t br_res;

    // model state
    ex_pkg::id_ex_t  held_m;
    ex_pkg::ex_mem_t exp_mem;
    ex_pkg::br_res_t exp_br;
    int unsigned     error_count;
    int unsigned     check_count;
    int unsigned     assert_count;
    bit              reset_ok;

    ex_stage ex_stage_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .stall  (stall),
        .flush  (flush),
        .ex_mem (ex_mem),
        .br_res (br_res)
    );

    bind ex_stage ex_stage_properties props_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_q (ctrl_inst.stall_q),
        .flush   (flush),
        .ex_mem  (ex_mem),
        .br_res  (br_res)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // release lines up with the other input drives
    initial begin
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
    end

    // corner values show up often
    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 7))
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            default: return $urandom();
        endcase
    endfunction

    function automatic logic [31:0] expected_alu_out(input ex_pkg::id_ex_t c);
        logic [4:0]  shamt;
        logic [63:0] sx1;
        logic [63:0] sx2;
        logic [63:0] zx1;
        logic [63:0] zx2;
        logic [63:0] p;
        shamt = c.op2[4:0];
        sx1 = {{32{c.op1[31]}}, c.op1};
        sx2 = {{32{c.op2[31]}}, c.op2};
        zx1 = {32'd0, c.op1};
        zx2 = {32'd0, c.op2};
        p = 64'd0;
        case (c.exe_fun)
            ex_pkg::alu_add:   return c.op1 + c.op2;
            ex_pkg::alu_sub:   return c.op1 - c.op2;
            ex_pkg::alu_and:   return c.op1 & c.op2;
            ex_pkg::alu_or:    return c.op1 | c.op2;
            ex_pkg::alu_xor:   return c.op1 ^ c.op2;
            ex_pkg::alu_sll:   return c.op1 << shamt;
            ex_pkg::alu_srl:   return c.op1 >> shamt;
            ex_pkg::alu_sra:   return $signed(c.op1) >>> shamt;
            ex_pkg::alu_slt:   return {31'd0, $signed(c.op1) < $signed(c.op2)};
            ex_pkg::alu_sltu:  return {31'd0, c.op1 < c.op2};
            ex_pkg::alu_jalr:  return (c.op1 + c.op2) & 32'hffff_fffe;
            ex_pkg::alu_copy1: return c.op1;
            ex_pkg::alu_mul:    p = sx1 * sx2;
            ex_pkg::alu_mulh:   p = sx1 * sx2;
            ex_pkg::alu_mulhsu: p = sx1 * zx2;
            ex_pkg::alu_mulhu:  p = zx1 * zx2;
            default:           return 32'd0;
        endcase
        if (`EX_EXCLUDE_RV32M != 0) begin
            return 32'd0;
        end
        return (c.exe_fun == ex_pkg::alu_mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic branch_taken(input ex_pkg::id_ex_t c);
        case (c.exe_fun)
            ex_pkg::br_beq:  return c.op1 == c.op2;
            ex_pkg::br_bne:  return c.op1 != c.op2;
            ex_pkg::br_blt:  return $signed(c.op1) < $signed(c.op2);
            ex_pkg::br_bge:  return $signed(c.op1) >= $signed(c.op2);
            ex_pkg::br_bltu: return c.op1 < c.op2;
            ex_pkg::br_bgeu: return c.op1 >= c.op2;
            default:         return 1'b0;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ex_mem(input ex_pkg::ex_mem_t got, input ex_pkg::ex_mem_t exp);
        compare_field("ex_mem.valid", 32'(got.valid), 32'(exp.valid));
        compare_field("ex_mem.pc", got.pc, exp.pc);
        compare_field("ex_mem.alu_out", got.alu_out, exp.alu_out);
        compare_field("ex_mem.op1", got.op1, exp.op1);
        compare_field("ex_mem.rs2_data", got.rs2_data, exp.rs2_data);
        compare_field("ex_mem.mem_wen", 32'(got.mem_wen), 32'(exp.mem_wen));
        compare_field("ex_mem.rf_wen", 32'(got.rf_wen), 32'(exp.rf_wen));
        compare_field("ex_mem.wb_sel", 32'(got.wb_sel), 32'(exp.wb_sel));
        compare_field("ex_mem.wb_addr", 32'(got.wb_addr), 32'(exp.wb_addr));
        compare_field("ex_mem.csr_cmd", 32'(got.csr_cmd), 32'(exp.csr_cmd));
        compare_field("ex_mem.jmp_flg", 32'(got.jmp_flg), 32'(exp.jmp_flg));
        compare_field("ex_mem.imm_i", got.imm_i, exp.imm_i);
    endtask

    task automatic check_br(input ex_pkg::br_res_t got, input ex_pkg::br_res_t exp);
        compare_field("br_res.br_flg", 32'(got.br_flg), 32'(exp.br_flg));
        compare_field("br_res.br_target", got.br_target, exp.br_target);
    endtask

    task automatic drive_random();
        ex_pkg::id_ex_t d;
        logic [4:0]     fun_code;
        logic [12:0]    b_imm;
        fun_code = 5'($urandom_range(0, 22));
        b_imm = 13'($urandom());
        d.valid = ($urandom_range(0, 9) != 0);
        d.pc = $urandom();
        d.exe_fun = ex_pkg::exe_fun_e'(fun_code);
        d.op1 = pick_operand();
        // equal pairs for beq/bge and friends
        d.op2 = ($urandom_range(0, 5) == 0) ? d.op1 : pick_operand();
        d.rs2_data = $urandom();
        d.mem_wen = 4'($urandom());
        d.rf_wen = 1'($urandom());
        d.wb_sel = 4'($urandom());
        d.wb_addr = 5'($urandom());
        d.csr_cmd = 3'($urandom());
        d.jmp_flg = 1'($urandom());
        d.imm_i = $urandom();
        d.imm_b = {{19{b_imm[12]}}, b_imm[12:1], 1'b0};
        id_ex = d;
        // stalls tend to come in runs
        stall = stall ? ($urandom_range(0, 99) < 35) : ($urandom_range(0, 99) < 20);
        flush = ($urandom_range(0, 99) < 10);
    endtask

    // expected outputs after the coming edge
    task automatic predict_outputs();
        ex_pkg::id_ex_t c;
        c = stall ? held_m : id_ex;
        exp_mem = ex_pkg::EX_MEM_BUBBLE;
        exp_br = ex_pkg::BR_RES_BUBBLE;
        if (flush) begin
            held_m = ex_pkg::ID_EX_BUBBLE;
        end else begin
            held_m = c;
            if (c.valid) begin
                exp_mem = '{valid: 1'b1, pc: c.pc, alu_out: expected_alu_out(c), op1: c.op1,
                            rs2_data: c.rs2_data, mem_wen: c.mem_wen, rf_wen: c.rf_wen,
                            wb_sel: c.wb_sel, wb_addr: c.wb_addr, csr_cmd: c.csr_cmd,
                            jmp_flg: c.jmp_flg, imm_i: c.imm_i};
                exp_br.br_flg = branch_taken(c);
                exp_br.br_target = c.pc + c.imm_b;
            end
        end
    endtask

    task automatic wait_reset_release(output bit ok);
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < RESET_LIMIT) begin
            @(posedge clk);
            #1;
            if (!rst_n) begin
                check_ex_mem(ex_mem, ex_pkg::EX_MEM_BUBBLE);
                check_br(br_res, ex_pkg::BR_RES_BUBBLE);
            end
            cycles++;
        end
        ok = rst_n;
    endtask

    initial begin
        rst_n = 1'b0;
        id_ex = ex_pkg::ID_EX_BUBBLE;
        stall = 1'b0;
        flush = 1'b0;
        held_m = ex_pkg::ID_EX_BUBBLE;
        error_count = 0;
        check_count = 0;
        void'($urandom(32'hda23_934f));
        wait_reset_release(reset_ok);
        if (!reset_ok) begin
            $display("reset was still asserted after %0d cycles", RESET_LIMIT);
            error_count++;
        end else begin
            // first edge out of reset
            check_ex_mem(ex_mem, ex_pkg::EX_MEM_BUBBLE);
            check_br(br_res, ex_pkg::BR_RES_BUBBLE);
            repeat (NUM_CYCLES) begin
                #1;
                drive_random();
                predict_outputs();
                @(posedge clk);
                #1;
                check_ex_mem(ex_mem, exp_mem);
                check_br(br_res, exp_br);
            end
        end
        assert_count = ex_stage_inst.props_inst.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_count);
        if (error_count == 0 && assert_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
